// ==== hdl/csr_pkg.sv ====
package csr_pkg;

  // Widths
  localparam int XLEN   = 32;
  localparam int CNT_W  = 64;
  localparam int ADDR_W = 12;

  typedef logic [XLEN-1:0]   csr_word_t;
  typedef logic [ADDR_W-1:0] csr_addr_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    S_MODE        = 2'd1,
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } mtvec_mode_t;

  // Machine trap setup
  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MSTATUSH_ADDR      = 12'h310;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;

  // Machine trap handling
  localparam csr_addr_t MSCRATCH_ADDR = 12'h340;
  localparam csr_addr_t MEPC_ADDR     = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR   = 12'h342;
  localparam csr_addr_t MTVAL_ADDR    = 12'h343;
  localparam csr_addr_t MIP_ADDR      = 12'h344;

  // Machine counters
  localparam csr_addr_t MCYCLE_ADDR    = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR  = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR   = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR = 12'hB82;

  // User counter views, read only
  localparam csr_addr_t CYCLE_ADDR    = 12'hC00;
  localparam csr_addr_t TIME_ADDR     = 12'hC01;
  localparam csr_addr_t INSTRET_ADDR  = 12'hC02;
  localparam csr_addr_t CYCLEH_ADDR   = 12'hC80;
  localparam csr_addr_t TIMEH_ADDR    = 12'hC81;
  localparam csr_addr_t INSTRETH_ADDR = 12'hC82;

  // Machine information
  localparam csr_addr_t MVENDORID_ADDR  = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR    = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR     = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR    = 12'hF14;
  localparam csr_addr_t MCONFIGPTR_ADDR = 12'hF15;

  // mstatus fields
  localparam int MIE_BIT  = 3;
  localparam int MPIE_BIT = 7;
  localparam int MPP_LSB  = 11; // Two bits wide
  localparam int MPRV_BIT = 17;
  localparam int TW_BIT   = 21;

  // mie and mip fields
  localparam int MSI_BIT = 3;
  localparam int MTI_BIT = 7;
  localparam int MEI_BIT = 11;
  localparam int MDI_BIT = 16;

  // mcounteren and mcountinhibit fields
  localparam int CY_BIT = 0;
  localparam int TM_BIT = 1;
  localparam int IR_BIT = 2;

  // RV32 base, I (bit 8) and U (bit 20)
  localparam csr_word_t MISA_VALUE     = 32'h4010_0100;
  localparam csr_word_t MSTATUSH_VALUE = 32'h0000_0000; // Little endian only

endpackage

// ==== hdl/csr_access_check.sv ====
`timescale 1ns/1ps

module csr_access_check (
  input  csr_pkg::csr_addr_t    csr_addr,
  input  logic                  csr_write,
  input  logic                  csr_set,
  input  logic                  csr_clear,
  input  logic                  valid_write,
  input  csr_pkg::csr_word_t    new_csr_val,
  input  csr_pkg::csr_word_t    rdata,
  input  csr_pkg::priv_level_t  priv_level,
  output csr_pkg::csr_word_t    wdata,
  output logic                  wr_en,
  output logic                  invalid_priv
);

  logic any_op;
  logic read_only;
  logic low_priv;

  assign any_op = csr_write | csr_set | csr_clear;

  // Top two address bits both set marks a read-only CSR
  assign read_only = &csr_addr[11:10];

  // Bits 9:8 hold the lowest level allowed to touch the CSR
  assign low_priv = csr_addr[9:8] > priv_level;

  // Operand merged with the old value for set and clear
  always_comb begin
    if (csr_set) begin
      wdata = rdata | new_csr_val;
    end else if (csr_clear) begin
      wdata = rdata & ~new_csr_val;
    end else begin
      wdata = new_csr_val; // Plain write
    end
  end

  assign invalid_priv = any_op & (read_only | low_priv);

  // Commit only legal operations
  assign wr_en = valid_write & any_op & ~invalid_priv;

endmodule

// ==== hdl/csr_trap_regs.sv ====
`timescale 1ns/1ps

module csr_trap_regs (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                wr_en,
  input  csr_pkg::csr_addr_t  csr_addr,
  input  csr_pkg::csr_word_t  wdata,
  input  logic                inject_mstatus,
  input  logic                inject_mepc,
  input  logic                inject_mcause,
  input  logic                inject_mtval,
  input  logic                inject_mip,
  input  csr_pkg::csr_word_t  next_mstatus,
  input  csr_pkg::csr_word_t  next_mepc,
  input  csr_pkg::csr_word_t  next_mcause,
  input  csr_pkg::csr_word_t  next_mtval,
  input  csr_pkg::csr_word_t  next_mip,
  output csr_pkg::csr_word_t  mstatus,
  output csr_pkg::csr_word_t  mtvec,
  output csr_pkg::csr_word_t  mie,
  output csr_pkg::csr_word_t  mip,
  output csr_pkg::csr_word_t  mscratch,
  output csr_pkg::csr_word_t  mepc,
  output csr_pkg::csr_word_t  mcause,
  output csr_pkg::csr_word_t  mtval,
  output csr_pkg::csr_word_t  mcounteren,
  output csr_pkg::csr_word_t  mcountinhibit
);

  // Writable fields of mstatus, everything else reads zero
  localparam csr_pkg::csr_word_t MSTATUS_WMASK = (32'd1 << csr_pkg::MIE_BIT)
                                               | (32'd1 << csr_pkg::MPIE_BIT)
                                               | (32'd3 << csr_pkg::MPP_LSB)
                                               | (32'd1 << csr_pkg::MPRV_BIT)
                                               | (32'd1 << csr_pkg::TW_BIT);
  localparam csr_pkg::csr_word_t IRQ_WMASK = (32'd1 << csr_pkg::MSI_BIT)
                                           | (32'd1 << csr_pkg::MTI_BIT)
                                           | (32'd1 << csr_pkg::MEI_BIT)
                                           | (32'd1 << csr_pkg::MDI_BIT);

  csr_pkg::csr_word_t mstatus_next, mtvec_next, mie_next, mip_next, mscratch_next;
  csr_pkg::csr_word_t mepc_next, mcause_next, mtval_next;
  csr_pkg::csr_word_t mcounteren_next, mcountinhibit_next;

  always_comb begin
    mstatus_next       = mstatus;
    mtvec_next         = mtvec;
    mie_next           = mie;
    mip_next           = mip;
    mscratch_next      = mscratch;
    mepc_next          = mepc;
    mcause_next        = mcause;
    mtval_next         = mtval;
    mcounteren_next    = mcounteren;
    mcountinhibit_next = mcountinhibit;

    if (wr_en) begin
      case (csr_addr)
        csr_pkg::MSTATUS_ADDR:       mstatus_next = wdata;
        csr_pkg::MTVEC_ADDR: begin
          if (wdata[1:0] > csr_pkg::VECTORED) begin
            mtvec_next = {wdata[31:2], csr_pkg::DIRECT}; // Reserved modes fall back
          end else begin
            mtvec_next = wdata;
          end
        end
        csr_pkg::MIE_ADDR:           mie_next = wdata & IRQ_WMASK;
        csr_pkg::MIP_ADDR:           mip_next = wdata;
        csr_pkg::MSCRATCH_ADDR:      mscratch_next = wdata;
        csr_pkg::MEPC_ADDR:          mepc_next = wdata;
        csr_pkg::MCAUSE_ADDR:        mcause_next = wdata;
        csr_pkg::MTVAL_ADDR:         mtval_next = wdata;
        csr_pkg::MCOUNTEREN_ADDR:    mcounteren_next = wdata;
        csr_pkg::MCOUNTINHIBIT_ADDR: mcountinhibit_next = wdata;
        default: ;
      endcase
    end

    // Trap side wins over software
    if (inject_mstatus) mstatus_next = next_mstatus;
    if (inject_mepc)    mepc_next = next_mepc;
    if (inject_mcause)  mcause_next = next_mcause;
    if (inject_mtval)   mtval_next = next_mtval;
    if (inject_mip)     mip_next = next_mip;

    // Field masks and mpp legalization cover both sources
    mstatus_next = mstatus_next & MSTATUS_WMASK;
    mip_next     = mip_next & IRQ_WMASK;
    if (mstatus_next[csr_pkg::MPP_LSB +: 2] inside {csr_pkg::S_MODE, csr_pkg::RESERVED_MODE})
      mstatus_next[csr_pkg::MPP_LSB +: 2] = csr_pkg::U_MODE; // No supervisor mode here
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= 32'd1 << csr_pkg::TW_BIT; // tw set, mpp U_MODE
      mtvec         <= '0;
      mie           <= '0;
      mip           <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= '1; // User counters open
      mcountinhibit <= '0;
    end else begin
      mstatus       <= mstatus_next;
      mtvec         <= mtvec_next;
      mie           <= mie_next;
      mip           <= mip_next;
      mscratch      <= mscratch_next;
      mepc          <= mepc_next;
      mcause        <= mcause_next;
      mtval         <= mtval_next;
      mcounteren    <= mcounteren_next;
      mcountinhibit <= mcountinhibit_next;
    end
  end

  mpp_legal: assert property (@(posedge CLK) disable iff (!nRST)
    !(mstatus[csr_pkg::MPP_LSB +: 2] inside {csr_pkg::S_MODE, csr_pkg::RESERVED_MODE}))
    else $error("csr_trap_regs: illegal mpp stored");

  mtvec_mode_legal: assert property (@(posedge CLK) disable iff (!nRST)
    mtvec[1:0] <= csr_pkg::VECTORED)
    else $error("csr_trap_regs: reserved mtvec mode stored");

endmodule

// ==== hdl/csr_counters.sv ====
`timescale 1ns/1ps

module csr_counters (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        wr_en,
  input  logic                        inst_ret,
  input  csr_pkg::csr_addr_t          csr_addr,
  input  csr_pkg::csr_word_t          wdata,
  input  csr_pkg::csr_word_t          mcountinhibit,
  output logic [csr_pkg::CNT_W-1:0]   cycle_count,
  output logic [csr_pkg::CNT_W-1:0]   instret_count
);

  localparam logic [csr_pkg::CNT_W-1:0] CNT_ONE = 1;

  logic [csr_pkg::CNT_W-1:0] cycle_next;
  logic [csr_pkg::CNT_W-1:0] instret_next;
  logic [csr_pkg::CNT_W-1:0] instret_step;

  assign instret_step = {{(csr_pkg::CNT_W-1){1'b0}}, inst_ret};

  always_comb begin
    cycle_next   = cycle_count;
    instret_next = instret_count;

    if (!mcountinhibit[csr_pkg::CY_BIT]) begin
      cycle_next = cycle_count + CNT_ONE;
    end
    if (!mcountinhibit[csr_pkg::IR_BIT]) begin
      instret_next = instret_count + instret_step; // Zero when nothing retires
    end

    // A half write replaces this cycle's increment
    if (wr_en) begin
      case (csr_addr)
        csr_pkg::MCYCLE_ADDR:
          cycle_next = {cycle_count[csr_pkg::CNT_W-1:csr_pkg::XLEN], wdata};
        csr_pkg::MCYCLEH_ADDR:
          cycle_next = {wdata, cycle_count[csr_pkg::XLEN-1:0]};
        csr_pkg::MINSTRET_ADDR:
          instret_next = {instret_count[csr_pkg::CNT_W-1:csr_pkg::XLEN], wdata};
        csr_pkg::MINSTRETH_ADDR:
          instret_next = {wdata, instret_count[csr_pkg::XLEN-1:0]};
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycle_count   <= '0;
      instret_count <= '0;
    end else begin
      cycle_count   <= cycle_next;
      instret_count <= instret_next;
    end
  end

endmodule

// ==== hdl/csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux #(
  parameter int HARTID = 0
) (
  input  csr_pkg::csr_addr_t          csr_addr,
  input  logic                        any_op,
  input  csr_pkg::priv_level_t        priv_level,
  input  csr_pkg::csr_word_t          mstatus,
  input  csr_pkg::csr_word_t          mtvec,
  input  csr_pkg::csr_word_t          mie,
  input  csr_pkg::csr_word_t          mip,
  input  csr_pkg::csr_word_t          mscratch,
  input  csr_pkg::csr_word_t          mepc,
  input  csr_pkg::csr_word_t          mcause,
  input  csr_pkg::csr_word_t          mtval,
  input  csr_pkg::csr_word_t          mcounteren,
  input  csr_pkg::csr_word_t          mcountinhibit,
  input  logic [csr_pkg::CNT_W-1:0]   cycle_count,
  input  logic [csr_pkg::CNT_W-1:0]   instret_count,
  input  logic [csr_pkg::CNT_W-1:0]   mtime,
  output csr_pkg::csr_word_t          rdata,
  output logic                        invalid_addr
);

  localparam int LO = csr_pkg::XLEN;

  logic cy_off, tm_off, ir_off;

  // User counter views closed by mcounteren in U_MODE only
  assign cy_off = (priv_level == csr_pkg::U_MODE) & ~mcounteren[csr_pkg::CY_BIT];
  assign tm_off = (priv_level == csr_pkg::U_MODE) & ~mcounteren[csr_pkg::TM_BIT];
  assign ir_off = (priv_level == csr_pkg::U_MODE) & ~mcounteren[csr_pkg::IR_BIT];

  always_comb begin
    rdata        = '0;
    invalid_addr = 1'b0;
    case (csr_addr)
      csr_pkg::MVENDORID_ADDR, csr_pkg::MARCHID_ADDR,
      csr_pkg::MIMPID_ADDR, csr_pkg::MCONFIGPTR_ADDR: rdata = '0;
      csr_pkg::MHARTID_ADDR:       rdata = csr_pkg::csr_word_t'(HARTID);
      csr_pkg::MISA_ADDR:          rdata = csr_pkg::MISA_VALUE;
      csr_pkg::MSTATUSH_ADDR:      rdata = csr_pkg::MSTATUSH_VALUE;
      csr_pkg::MSTATUS_ADDR:       rdata = mstatus;
      csr_pkg::MTVEC_ADDR:         rdata = mtvec;
      csr_pkg::MIE_ADDR:           rdata = mie;
      csr_pkg::MIP_ADDR:           rdata = mip;
      csr_pkg::MSCRATCH_ADDR:      rdata = mscratch;
      csr_pkg::MEPC_ADDR:          rdata = mepc;
      csr_pkg::MCAUSE_ADDR:        rdata = mcause;
      csr_pkg::MTVAL_ADDR:         rdata = mtval;
      csr_pkg::MCOUNTEREN_ADDR:    rdata = mcounteren;
      csr_pkg::MCOUNTINHIBIT_ADDR: rdata = mcountinhibit;
      csr_pkg::MCYCLE_ADDR:        rdata = cycle_count[LO-1:0];
      csr_pkg::MCYCLEH_ADDR:       rdata = cycle_count[csr_pkg::CNT_W-1:LO];
      csr_pkg::MINSTRET_ADDR:      rdata = instret_count[LO-1:0];
      csr_pkg::MINSTRETH_ADDR:     rdata = instret_count[csr_pkg::CNT_W-1:LO];
      // Gated views return zero when closed
      csr_pkg::CYCLE_ADDR: begin
        if (cy_off) invalid_addr = 1'b1;
        else rdata = cycle_count[LO-1:0];
      end
      csr_pkg::CYCLEH_ADDR: begin
        if (cy_off) invalid_addr = 1'b1;
        else rdata = cycle_count[csr_pkg::CNT_W-1:LO];
      end
      csr_pkg::TIME_ADDR: begin
        if (tm_off) invalid_addr = 1'b1;
        else rdata = mtime[LO-1:0];
      end
      csr_pkg::TIMEH_ADDR: begin
        if (tm_off) invalid_addr = 1'b1;
        else rdata = mtime[csr_pkg::CNT_W-1:LO];
      end
      csr_pkg::INSTRET_ADDR: begin
        if (ir_off) invalid_addr = 1'b1;
        else rdata = instret_count[LO-1:0];
      end
      csr_pkg::INSTRETH_ADDR: begin
        if (ir_off) invalid_addr = 1'b1;
        else rdata = instret_count[csr_pkg::CNT_W-1:LO];
      end
      default: invalid_addr = any_op; // Unknown CSR, only an access counts
    endcase
  end

endmodule

// ==== hdl/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit #(
  parameter int HARTID = 0
) (
  input  logic                        CLK,
  input  logic                        nRST,
  input  csr_pkg::csr_addr_t          csr_addr,
  input  logic                        csr_write,
  input  logic                        csr_set,
  input  logic                        csr_clear,
  input  csr_pkg::csr_word_t          new_csr_val,
  input  logic                        valid_write,
  input  csr_pkg::priv_level_t        priv_level,
  input  logic                        inst_ret,
  input  logic [csr_pkg::CNT_W-1:0]   mtime,
  input  logic                        inject_mstatus,
  input  logic                        inject_mepc,
  input  logic                        inject_mcause,
  input  logic                        inject_mtval,
  input  logic                        inject_mip,
  input  csr_pkg::csr_word_t          next_mstatus,
  input  csr_pkg::csr_word_t          next_mepc,
  input  csr_pkg::csr_word_t          next_mcause,
  input  csr_pkg::csr_word_t          next_mtval,
  input  csr_pkg::csr_word_t          next_mip,
  output csr_pkg::csr_word_t          rdata,
  output logic                        invalid_csr,
  output csr_pkg::csr_word_t          curr_mstatus,
  output csr_pkg::csr_word_t          curr_mie,
  output csr_pkg::csr_word_t          curr_mip,
  output csr_pkg::csr_word_t          curr_mtvec,
  output csr_pkg::csr_word_t          curr_mepc,
  output csr_pkg::csr_word_t          curr_mcause
);

  csr_pkg::csr_word_t wdata;
  logic               wr_en, any_op, invalid_priv, invalid_addr;
  csr_pkg::csr_word_t mstatus, mtvec, mie, mip, mscratch, mepc, mcause, mtval;
  csr_pkg::csr_word_t mcounteren, mcountinhibit;
  logic [csr_pkg::CNT_W-1:0] cycle_count, instret_count;

  assign any_op      = csr_write | csr_set | csr_clear;
  assign invalid_csr = invalid_priv | invalid_addr;

  csr_access_check u_access (
    .csr_addr, .csr_write, .csr_set, .csr_clear, .valid_write,
    .new_csr_val, .rdata, .priv_level, .wdata, .wr_en, .invalid_priv
  );

  csr_trap_regs u_trap_regs (
    .CLK, .nRST, .wr_en, .csr_addr, .wdata,
    .inject_mstatus, .inject_mepc, .inject_mcause, .inject_mtval, .inject_mip,
    .next_mstatus, .next_mepc, .next_mcause, .next_mtval, .next_mip,
    .mstatus, .mtvec, .mie, .mip, .mscratch, .mepc, .mcause, .mtval,
    .mcounteren, .mcountinhibit
  );

  csr_counters u_counters (
    .CLK, .nRST, .wr_en, .inst_ret, .csr_addr, .wdata, .mcountinhibit,
    .cycle_count, .instret_count
  );

  csr_read_mux #(.HARTID(HARTID)) u_read_mux (
    .csr_addr, .any_op, .priv_level,
    .mstatus, .mtvec, .mie, .mip, .mscratch, .mepc, .mcause, .mtval,
    .mcounteren, .mcountinhibit, .cycle_count, .instret_count, .mtime,
    .rdata, .invalid_addr
  );

  // Live state for the trap and interrupt logic
  assign curr_mstatus = mstatus;
  assign curr_mie     = mie;
  assign curr_mip     = mip;
  assign curr_mtvec   = mtvec;
  assign curr_mepc    = mepc;
  assign curr_mcause  = mcause;

endmodule

// ==== verif/csr_unit_tb_table.svh ====
  // Columns: name, address, operation, valid_write, operand, privilege,
  // expected rdata one cycle later, expected invalid_csr in the access cycle
  task automatic fill_table();
    csr_pkg::csr_word_t r1;
    csr_pkg::csr_word_t r2;
    csr_pkg::csr_word_t r3;
    csr_pkg::csr_word_t scratch;
    r1 = $random(seed);
    r2 = $random(seed);
    r3 = $random(seed);
    scratch = r1;
    // Reset values
    add_row("mhartid reset", csr_pkg::MHARTID_ADDR, OP_NONE, 1'b0, 32'd0, csr_pkg::M_MODE,
            32'(HARTID), 1'b0);
    add_row("misa reset", csr_pkg::MISA_ADDR, OP_NONE, 1'b0, 32'd0, csr_pkg::M_MODE,
            (32'd1 << 30) | (32'd1 << 20) | (32'd1 << 8), 1'b0);
    add_row("mvendorid reset", csr_pkg::MVENDORID_ADDR, OP_NONE, 1'b0, 32'd0, csr_pkg::M_MODE,
            32'd0, 1'b0);
    add_row("mstatus reset", csr_pkg::MSTATUS_ADDR, OP_NONE, 1'b0, 32'd0, csr_pkg::M_MODE,
            32'd1 << 21, 1'b0);
    add_row("mcounteren reset", csr_pkg::MCOUNTEREN_ADDR, OP_NONE, 1'b0, 32'd0,
            csr_pkg::M_MODE, 32'hffff_ffff, 1'b0);
    // mscratch write, set and clear
    add_row("mscratch write", csr_pkg::MSCRATCH_ADDR, OP_WRITE, 1'b1, r1, csr_pkg::M_MODE,
            scratch, 1'b0);
    scratch = scratch | r2;
    add_row("mscratch set", csr_pkg::MSCRATCH_ADDR, OP_SET, 1'b1, r2, csr_pkg::M_MODE,
            scratch, 1'b0);
    scratch = scratch & ~r3;
    add_row("mscratch clear", csr_pkg::MSCRATCH_ADDR, OP_CLEAR, 1'b1, r3, csr_pkg::M_MODE,
            scratch, 1'b0);
    // mpp of S_MODE lands as U_MODE, tw and mie survive
    add_row("mstatus mpp legal", csr_pkg::MSTATUS_ADDR, OP_WRITE, 1'b1, 32'h0020_0808,
            csr_pkg::M_MODE, 32'h0020_0008, 1'b0);
    add_row("mtvec mode legal", csr_pkg::MTVEC_ADDR, OP_WRITE, 1'b1, 32'h8000_0103,
            csr_pkg::M_MODE, 32'h8000_0100, 1'b0);
    // Only bits 3, 7, 11 and 16 stick in mie
    add_row("mie write mask", csr_pkg::MIE_ADDR, OP_WRITE, 1'b1, 32'hffff_ffff,
            csr_pkg::M_MODE, 32'h0001_0888, 1'b0);
    // Access checks in U_MODE
    add_row("user mscratch write", csr_pkg::MSCRATCH_ADDR, OP_WRITE, 1'b1, 32'hdead_beef,
            csr_pkg::U_MODE, scratch, 1'b1);
    add_row("user mhartid write", csr_pkg::MHARTID_ADDR, OP_WRITE, 1'b1, 32'h0000_0001,
            csr_pkg::U_MODE, 32'(HARTID), 1'b1);
    add_row("mcounteren clear cy", csr_pkg::MCOUNTEREN_ADDR, OP_CLEAR, 1'b1, 32'h0000_0001,
            csr_pkg::M_MODE, 32'hffff_fffe, 1'b0);
    add_row("user cycle closed", csr_pkg::CYCLE_ADDR, OP_NONE, 1'b0, 32'd0, csr_pkg::U_MODE,
            32'd0, 1'b1);
    add_row("user unknown csr", 12'h0FF, OP_WRITE, 1'b1, 32'h1234_0000, csr_pkg::U_MODE,
            32'd0, 1'b1);
    // Counters, cycle and instret inhibited first
    add_row("mcountinhibit set", csr_pkg::MCOUNTINHIBIT_ADDR, OP_WRITE, 1'b1, 32'h0000_0005,
            csr_pkg::M_MODE, 32'h0000_0005, 1'b0);
    add_row("mcycle write", csr_pkg::MCYCLE_ADDR, OP_WRITE, 1'b1, 32'h1234_5678,
            csr_pkg::M_MODE, 32'h1234_5678, 1'b0);
    add_row("mcycle hold", csr_pkg::MCYCLE_ADDR, OP_NONE, 1'b0, 32'd0, csr_pkg::M_MODE,
            32'h1234_5678, 1'b0);
    add_row("user time low", csr_pkg::TIME_ADDR, OP_NONE, 1'b0, 32'd0, csr_pkg::U_MODE,
            MTIME_VALUE[31:0], 1'b0);
    add_row("user time high", csr_pkg::TIMEH_ADDR, OP_NONE, 1'b0, 32'd0, csr_pkg::U_MODE,
            MTIME_VALUE[63:32], 1'b0);
    add_row("mcountinhibit clear", csr_pkg::MCOUNTINHIBIT_ADDR, OP_WRITE, 1'b1, 32'd0,
            csr_pkg::M_MODE, 32'd0, 1'b0);
  endtask

// ==== verif/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb;

  localparam int HARTID   = 5;
  localparam logic [63:0] MTIME_VALUE = 64'h0000_0042_89ab_cdef;

  localparam logic [1:0] OP_NONE  = 2'd0;
  localparam logic [1:0] OP_WRITE = 2'd1;
  localparam logic [1:0] OP_SET   = 2'd2;
  localparam logic [1:0] OP_CLEAR = 2'd3;

  typedef struct {
    string                name;
    csr_pkg::csr_addr_t   addr;
    logic [1:0]           op;
    logic                 valid_write;
    csr_pkg::csr_word_t   operand;
    csr_pkg::priv_level_t priv;
    csr_pkg::csr_word_t   exp_rdata;
    logic                 exp_invalid;
  } row_t;

  logic                 CLK;
  logic                 nRST;
  csr_pkg::csr_addr_t   csr_addr;
  logic                 csr_write, csr_set, csr_clear;
  csr_pkg::csr_word_t   new_csr_val;
  logic                 valid_write;
  csr_pkg::priv_level_t priv_level;
  logic                 inst_ret;
  logic [63:0]          mtime;
  logic                 inject_mstatus, inject_mepc, inject_mcause, inject_mtval, inject_mip;
  csr_pkg::csr_word_t   next_mstatus, next_mepc, next_mcause, next_mtval, next_mip;
  csr_pkg::csr_word_t   rdata;
  logic                 invalid_csr;
  csr_pkg::csr_word_t   curr_mstatus, curr_mie, curr_mip, curr_mtvec, curr_mepc, curr_mcause;

  row_t   rows[$];
  integer seed;

  csr_unit #(.HARTID(HARTID)) u_csr_unit (.*);

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic compare(input string name, input csr_pkg::csr_word_t expected,
                         input csr_pkg::csr_word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic drive_op(input logic [1:0] op);
    csr_write = (op == OP_WRITE);
    csr_set   = (op == OP_SET);
    csr_clear = (op == OP_CLEAR);
  endtask

  task automatic add_row(input string name, input csr_pkg::csr_addr_t addr,
                         input logic [1:0] op, input logic vw, input csr_pkg::csr_word_t operand,
                         input csr_pkg::priv_level_t priv, input csr_pkg::csr_word_t exp_rdata,
                         input logic exp_invalid);
    row_t r;
    r.name        = name;
    r.addr        = addr;
    r.op          = op;
    r.valid_write = vw;
    r.operand     = operand;
    r.priv        = priv;
    r.exp_rdata   = exp_rdata;
    r.exp_invalid = exp_invalid;
    rows.push_back(r);
  endtask

  `include "csr_unit_tb_table.svh"

  // Access cycle checks invalid_csr, the following cycle reads back
  task automatic apply_row(input row_t r);
    next_cycle();
    csr_addr    = r.addr;
    drive_op(r.op);
    valid_write = r.valid_write;
    new_csr_val = r.operand;
    priv_level  = r.priv;
    #2;
    compare({r.name, " invalid"}, {31'd0, r.exp_invalid}, {31'd0, invalid_csr});
    next_cycle();
    drive_op(OP_NONE);
    valid_write = 1'b0;
    #2;
    compare({r.name, " rdata"}, r.exp_rdata, rdata);
  endtask

  // No instruction has retired before this point
  task automatic count_retired();
    next_cycle();
    csr_addr   = csr_pkg::MINSTRET_ADDR;
    priv_level = csr_pkg::M_MODE;
    repeat (4) begin
      inst_ret = 1'b1;
      next_cycle();
      inst_ret = 1'b0;
      next_cycle();
    end
    #2;
    compare("minstret after four retirements", 32'd4, rdata);
  endtask

  // Trap side and software hit mepc in the same cycle
  task automatic inject_over_write();
    next_cycle();
    csr_addr      = csr_pkg::MEPC_ADDR;
    drive_op(OP_WRITE);
    valid_write   = 1'b1;
    new_csr_val   = 32'h0000_1000;
    inject_mepc   = 1'b1;
    next_mepc     = 32'h8000_0040;
    inject_mcause = 1'b1;
    next_mcause   = 32'h8000_000b;
    inject_mip    = 1'b1;
    next_mip      = 32'h0000_0880;
    next_cycle();
    drive_op(OP_NONE);
    valid_write   = 1'b0;
    inject_mepc   = 1'b0;
    inject_mcause = 1'b0;
    inject_mip    = 1'b0;
    #2;
    compare("curr_mepc after injection", 32'h8000_0040, curr_mepc);
    compare("curr_mcause after injection", 32'h8000_000b, curr_mcause);
    compare("curr_mip after injection", 32'h0000_0880, curr_mip);
    compare("mepc read after injection", 32'h8000_0040, rdata);
    // State left by the table rows
    compare("curr_mstatus", 32'h0020_0008, curr_mstatus);
    compare("curr_mie", 32'h0001_0888, curr_mie);
    compare("curr_mtvec", 32'h8000_0100, curr_mtvec);
  endtask

  initial begin
    seed           = 32'hc71a;
    nRST           = 1'b0;
    csr_addr       = '0;
    drive_op(OP_NONE);
    new_csr_val    = '0;
    valid_write    = 1'b0;
    priv_level     = csr_pkg::M_MODE;
    inst_ret       = 1'b0;
    mtime          = MTIME_VALUE;
    inject_mstatus = 1'b0;
    inject_mepc    = 1'b0;
    inject_mcause  = 1'b0;
    inject_mtval   = 1'b0;
    inject_mip     = 1'b0;
    next_mstatus   = '0;
    next_mepc      = '0;
    next_mcause    = '0;
    next_mtval     = '0;
    next_mip       = '0;
    repeat (16) @(posedge CLK);
    #1;
    nRST = 1'b1;

    fill_table();
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    count_retired();
    inject_over_write();

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== csr_unit.f ====
+incdir+verif
hdl/csr_pkg.sv
hdl/csr_access_check.sv
hdl/csr_trap_regs.sv
hdl/csr_counters.sv
hdl/csr_read_mux.sv
hdl/csr_unit.sv
verif/csr_unit_tb.sv

// ==== Makefile ====
TOP = csr_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f csr_unit.f --top-module csr_unit

# A failing run ends in $fatal, which gives make a nonzero status
sim:
	verilator --binary --timing --assert -f csr_unit.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
